// File: logic/video_timing_pkg.sv
// Raster constants for a 640x480 display with an 801 by 526 clock frame
// Counter limits are the last value reached before wrapping to 0
`default_nettype none

package video_timing_pkg;

  typedef logic [9:0] coord_t;

  // Last counter values before wrap
  localparam coord_t h_last = 10'd800;
  localparam coord_t v_last = 10'd525;

  // Visible area
  localparam coord_t h_active = 10'd640;
  localparam coord_t v_active = 10'd480;

  // Sync pulses, both ends inclusive
  localparam coord_t hs_start = 10'd656;
  localparam coord_t hs_end   = 10'd751;
  localparam coord_t vs_start = 10'd490;
  localparam coord_t vs_end   = 10'd492;

  // Half-open bitmap window
  localparam coord_t win_x0 = 10'd64;
  localparam coord_t win_x1 = 10'd576;
  localparam coord_t win_y0 = 10'd48;
  localparam coord_t win_y1 = 10'd432;

  // Fetch runs one 16-pixel group ahead of the window edge
  localparam coord_t fetch_offset = 10'd48;

endpackage

`default_nettype wire

// File: logic/frame_pkg.sv
// Frame memory layout for a 256x192 bitmap with 32x24 attribute cells
// Addresses at or above fb_limit are not backed by memory
`default_nettype none

package frame_pkg;

  typedef logic [13:0] fb_addr_t;
  typedef logic [7:0]  fb_byte_t;

  // Physical memory size in bytes
  localparam int fb_depth = 8192;

  // Bitmap is row * 32 + column, attributes are (row / 8) * 32 + column
  localparam fb_addr_t bitmap_base = 14'h0000;
  localparam fb_addr_t attr_base   = 14'h1800;
  localparam fb_addr_t fb_limit    = 14'h1B00;

  typedef logic [4:0] red_t;
  typedef logic [5:0] green_t;
  typedef logic [4:0] blue_t;

  // Only legal non-zero level per component
  localparam red_t   red_half   = 5'h0F;
  localparam green_t green_half = 6'h1F;
  localparam blue_t  blue_half  = 5'h0F;

  // Attribute fields and the bit order inside a 3-bit colour
  localparam int ink_lsb    = 0;
  localparam int paper_lsb  = 3;
  localparam int col_blue   = 0;
  localparam int col_red    = 1;
  localparam int col_green  = 2;

endpackage

`default_nettype wire

// File: logic/raster_if.sv
// Raster position and syncs, updated every clock by the timing generator
// No handshake; sinks sample whatever is present in the current cycle
`default_nettype none

interface raster_if;

  video_timing_pkg::coord_t x;
  video_timing_pkg::coord_t y;
  logic                     hs;
  logic                     vs;

  // Timing generator side
  modport source (output x, output y, output hs, output vs);

  // Fetch and colour stages
  modport sink (input x, input y, input hs, input vs);

endinterface

`default_nettype wire

// File: logic/video_timing.sv
// Free-running raster counters; x and y are both 0 in the first cycle after reset
// Syncs are active high and decoded without a register
`default_nettype none

module video_timing (
  input  logic    clock,
  input  logic    reset,
  raster_if.source raster
);

  video_timing_pkg::coord_t x_count;
  video_timing_pkg::coord_t y_count;
  logic                     x_wrap;
  logic                     y_wrap;

  assign x_wrap = (x_count == video_timing_pkg::h_last);
  assign y_wrap = (y_count == video_timing_pkg::v_last);

  always_ff @(posedge clock) begin
    if (reset) begin
      x_count <= '0;
      y_count <= '0;
    end else begin
      if (x_wrap) begin
        x_count <= '0;
        // Line advances only at the end of a line
        y_count <= y_wrap ? '0 : y_count + 10'd1;
      end else begin
        x_count <= x_count + 10'd1;
      end
    end
  end

  assign raster.x = x_count;
  assign raster.y = y_count;

  assign raster.hs = (x_count >= video_timing_pkg::hs_start) &&
                     (x_count <= video_timing_pkg::hs_end);
  assign raster.vs = (y_count >= video_timing_pkg::vs_start) &&
                     (y_count <= video_timing_pkg::vs_end);

endmodule

`default_nettype wire

// File: logic/apb_frame_port.sv
// APB slave with exactly one wait state per transfer
// Out-of-range addresses return pslverr and zero data without a memory access
`default_nettype none

module apb_frame_port (
  input  logic                clock,
  input  logic                reset,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  frame_pkg::fb_addr_t paddr,
  input  frame_pkg::fb_byte_t pwdata,
  output frame_pkg::fb_byte_t prdata,
  output logic                pready,
  output logic                pslverr,
  output logic                host_en,
  output logic                host_we,
  output frame_pkg::fb_addr_t host_addr,
  output frame_pkg::fb_byte_t host_wdata,
  input  frame_pkg::fb_byte_t host_rdata
);

  typedef enum logic [1:0] {st_idle, st_access, st_ready} state_t;

  state_t state;
  state_t state_next;
  logic   bad_addr;

  assign bad_addr = (paddr >= frame_pkg::fb_limit);

  always_comb begin
    state_next = state;
    case (state)
      st_idle:   if (psel && !penable) state_next = st_access;
      // First access cycle issues the memory access
      st_access: state_next = (psel && penable) ? st_ready : st_idle;
      st_ready:  state_next = st_idle;
      default:   state_next = st_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  assign host_en    = (state == st_access) && psel && penable && !bad_addr;
  assign host_we    = pwrite;
  assign host_addr  = paddr;
  assign host_wdata = pwdata;

  // Read data arrives one cycle after the access, in the ready cycle
  assign pready  = (state == st_ready);
  assign pslverr = pready && bad_addr;
  assign prdata  = (pready && !bad_addr && !pwrite) ? host_rdata : '0;

endmodule

`default_nettype wire

// File: logic/frame_ram.sv
// 8 KB dual-port byte memory with one cycle of read latency on both ports
// Address bit 13 is ignored, so upper addresses alias the lower half
`default_nettype none

module frame_ram (
  input  logic                clock,
  input  logic                host_en,
  input  logic                host_we,
  input  frame_pkg::fb_addr_t host_addr,
  input  frame_pkg::fb_byte_t host_wdata,
  output frame_pkg::fb_byte_t host_rdata,
  input  frame_pkg::fb_addr_t disp_addr,
  output frame_pkg::fb_byte_t disp_rdata
);

  frame_pkg::fb_byte_t mem [frame_pkg::fb_depth];

  // Host port, read or write per access
  always_ff @(posedge clock) begin
    if (host_en) begin
      if (host_we) begin
        mem[host_addr[12:0]] <= host_wdata;
      end else begin
        host_rdata <= mem[host_addr[12:0]];
      end
    end
  end

  // Display port reads every cycle
  always_ff @(posedge clock) begin
    disp_rdata <= mem[disp_addr[12:0]];
  end

endmodule

`default_nettype wire

// File: logic/bitmap_fetch.sv
// Fetches one bitmap and one attribute byte per 16-pixel group, one group early
// Addresses outside the window are fetched but never shown
`default_nettype none

module bitmap_fetch (
  input  logic                clock,
  input  logic                reset,
  raster_if.sink              raster,
  output frame_pkg::fb_addr_t disp_addr,
  input  frame_pkg::fb_byte_t disp_rdata,
  output frame_pkg::fb_byte_t mask,
  output frame_pkg::fb_byte_t attr
);

  video_timing_pkg::coord_t rx;
  video_timing_pkg::coord_t ry;
  logic [3:0]               nibble;
  logic [4:0]               column;
  frame_pkg::fb_addr_t      bitmap_addr;
  frame_pkg::fb_addr_t      attr_addr;
  frame_pkg::fb_byte_t      bitmap_byte;

  // Fetch position relative to the window origin minus one group
  assign rx = raster.x - video_timing_pkg::fetch_offset;
  assign ry = raster.y - video_timing_pkg::fetch_offset;

  assign nibble = rx[3:0];
  assign column = rx[8:4];

  // Pixel rows are doubled, so bitmap row is ry / 2 and cell row is ry / 16
  assign bitmap_addr = frame_pkg::bitmap_base + {1'b0, ry[8:1], column};
  assign attr_addr   = frame_pkg::attr_base + {4'b0000, ry[8:4], column};

  // Bitmap address only in nibble 0, attribute address for the rest of the group
  assign disp_addr = (nibble == 4'd0) ? bitmap_addr : attr_addr;

  always_ff @(posedge clock) begin
    if (reset) begin
      bitmap_byte <= '0;
      mask        <= '0;
      attr        <= '0;
    end else begin
      if (nibble == 4'd1) begin
        bitmap_byte <= disp_rdata;
      end
      // Hand over to the display at the group boundary
      if (nibble == 4'd15) begin
        mask <= bitmap_byte;
        attr <= disp_rdata;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/pixel_colour.sv
// Colour stage with registered outputs, one clock behind the raster position
// Components are only ever 0 or the half level
`default_nettype none

module pixel_colour (
  input  logic                clock,
  input  logic                reset,
  raster_if.sink              raster,
  input  frame_pkg::fb_byte_t mask,
  input  frame_pkg::fb_byte_t attr,
  output frame_pkg::red_t     r,
  output frame_pkg::green_t   g,
  output frame_pkg::blue_t    b,
  output logic                hs,
  output logic                vs
);

  video_timing_pkg::coord_t rx;
  logic                     active;
  logic                     in_window;
  logic                     bit_set;
  logic [2:0]               colour;
  frame_pkg::red_t          r_next;
  frame_pkg::green_t        g_next;
  frame_pkg::blue_t         b_next;

  assign rx = raster.x - video_timing_pkg::fetch_offset;

  assign active = (raster.x < video_timing_pkg::h_active) &&
                  (raster.y < video_timing_pkg::v_active);

  assign in_window = (raster.x >= video_timing_pkg::win_x0) &&
                     (raster.x <  video_timing_pkg::win_x1) &&
                     (raster.y >= video_timing_pkg::win_y0) &&
                     (raster.y <  video_timing_pkg::win_y1);

  // Leftmost pixel pair shows bit 7
  assign bit_set = mask[3'd7 - rx[3:1]];
  assign colour  = bit_set ? attr[frame_pkg::ink_lsb +: 3] : attr[frame_pkg::paper_lsb +: 3];

  always_comb begin
    if (!active) begin
      r_next = '0;
      g_next = '0;
      b_next = '0;
    end else if (!in_window) begin
      // Fixed grey border
      r_next = frame_pkg::red_half;
      g_next = frame_pkg::green_half;
      b_next = frame_pkg::blue_half;
    end else begin
      r_next = colour[frame_pkg::col_red]   ? frame_pkg::red_half   : '0;
      g_next = colour[frame_pkg::col_green] ? frame_pkg::green_half : '0;
      b_next = colour[frame_pkg::col_blue]  ? frame_pkg::blue_half  : '0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      r  <= '0;
      g  <= '0;
      b  <= '0;
      hs <= 1'b0;
      vs <= 1'b0;
    end else begin
      r  <= r_next;
      g  <= g_next;
      b  <= b_next;
      hs <= raster.hs;
      vs <= raster.vs;
    end
  end

endmodule

`default_nettype wire

// File: logic/video_top.sv
// Video subsystem top with an APB host port and 5/6/5 RGB output
// Outputs describe the raster position of the previous clock
`default_nettype none

module video_top (
  input  logic                clock,
  input  logic                reset,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  frame_pkg::fb_addr_t paddr,
  input  frame_pkg::fb_byte_t pwdata,
  output frame_pkg::fb_byte_t prdata,
  output logic                pready,
  output logic                pslverr,
  output frame_pkg::red_t     r,
  output frame_pkg::green_t   g,
  output frame_pkg::blue_t    b,
  output logic                hs,
  output logic                vs
);

  logic                host_en;
  logic                host_we;
  frame_pkg::fb_addr_t host_addr;
  frame_pkg::fb_byte_t host_wdata;
  frame_pkg::fb_byte_t host_rdata;
  frame_pkg::fb_addr_t disp_addr;
  frame_pkg::fb_byte_t disp_rdata;
  frame_pkg::fb_byte_t mask;
  frame_pkg::fb_byte_t attr;

  raster_if raster ();

  video_timing u_timing (
    .clock  (clock),
    .reset  (reset),
    .raster (raster.source)
  );

  apb_frame_port u_apb (
    .clock      (clock),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .host_en    (host_en),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata)
  );

  frame_ram u_ram (
    .clock      (clock),
    .host_en    (host_en),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .disp_addr  (disp_addr),
    .disp_rdata (disp_rdata)
  );

  bitmap_fetch u_fetch (
    .clock      (clock),
    .reset      (reset),
    .raster     (raster.sink),
    .disp_addr  (disp_addr),
    .disp_rdata (disp_rdata),
    .mask       (mask),
    .attr       (attr)
  );

  pixel_colour u_colour (
    .clock  (clock),
    .reset  (reset),
    .raster (raster.sink),
    .mask   (mask),
    .attr   (attr),
    .r      (r),
    .g      (g),
    .b      (b),
    .hs     (hs),
    .vs     (vs)
  );

endmodule

`default_nettype wire

// File: verification/video_top_tb.sv
// Testbench for video_top that must run from the project root to find its test data file
// Pixel probes sample the second frame, so a run lasts close to two raster frames
`default_nettype none

module video_top_tb;

  localparam int frame_clocks = 801 * 526;
  localparam int max_probes   = 64;

  logic        clock;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [13:0] paddr;
  logic [7:0]  pwdata;
  logic [7:0]  prdata;
  logic        pready;
  logic        pslverr;
  logic [4:0]  r;
  logic [5:0]  g;
  logic [4:0]  b;
  logic        hs;
  logic        vs;

  int          out_pos;
  int          pass_count;
  int          fail_count;
  int          probe_count;
  logic [31:0] rng_state;

  // Pixel probes are checked in raster order
  logic [8*24-1:0] probe_name [max_probes];
  int              probe_pos  [max_probes];
  logic [15:0]     probe_rgb  [max_probes];
  logic            probe_done [max_probes];

  video_top u_dut (
    .clock   (clock),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .r       (r),
    .g       (g),
    .b       (b),
    .hs      (hs),
    .vs      (vs)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Raster index that the outputs currently describe
  // Stays at -1 until the first cycle after reset
  always @(posedge clock) begin
    if (reset) begin
      out_pos <= -1;
    end else begin
      out_pos <= out_pos + 1;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic int raster_index(input int frame, input int x, input int y);
    return frame * frame_clocks + y * 801 + x;
  endfunction

  // Blue in bit 0, red in bit 1 and green in bit 2, each at half level
  function automatic logic [15:0] expand_colour(input logic [2:0] c);
    logic [4:0] rv;
    logic [5:0] gv;
    logic [4:0] bv;
    rv = c[1] ? 5'h0F : 5'h00;
    gv = c[2] ? 6'h1F : 6'h00;
    bv = c[0] ? 5'h0F : 5'h00;
    return {rv, gv, bv};
  endfunction

  task automatic check_value(input logic [8*24-1:0] name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual === expected) begin
      $display("ok     %0s", name);
      pass_count++;
    end else begin
      $display("FAILED %0s expected %h actual %h", name, expected, actual);
      fail_count++;
    end
  endtask

  task automatic wait_output(input int target);
    int waited;
    waited = 0;
    while (out_pos < target && waited < 2 * frame_clocks) begin
      @(negedge clock);
      waited++;
    end
    if (out_pos != target) begin
      $display("Raster index %0d never reached, outputs are at %0d", target, out_pos);
      $display("Test failures found");
      $finish;
    end
  endtask

  // Response is {pslverr, prdata} from the cycle with pready high
  task automatic apb_transfer(input logic [8*24-1:0] name, input logic write,
                              input logic [13:0] addr, input logic [7:0] data,
                              output logic [8:0] response);
    int waited;
    @(negedge clock);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    @(negedge clock);
    penable = 1'b1;
    if (pready) begin
      $display("%0s: pready came without the wait state", name);
      fail_count++;
    end
    waited = 0;
    @(negedge clock);
    while (!pready && waited < 16) begin
      @(negedge clock);
      waited++;
    end
    if (!pready) begin
      $display("%0s: pready never came within 16 cycles", name);
      $display("Test failures found");
      $finish;
    end else begin
      if (waited != 0) begin
        $display("%0s: pready came %0d cycles after the single wait state", name, waited);
        fail_count++;
      end
      response = {pslverr, prdata};
      // Transfer completes on the rising edge of the ready cycle
      @(negedge clock);
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  task automatic add_probe(input logic [8*24-1:0] name, input int pos,
                           input logic [15:0] rgb);
    probe_name[probe_count] = name;
    probe_pos[probe_count]  = pos;
    probe_rgb[probe_count]  = rgb;
    probe_done[probe_count] = 1'b0;
    probe_count++;
  endtask

  // APB lines run at once and pixel lines become probes of the second frame
  task automatic run_test_file();
    int               fd;
    int               n;
    int               x;
    int               y;
    logic [31:0]      addr;
    logic [31:0]      wdata;
    logic [31:0]      rdata;
    logic [31:0]      err;
    logic [31:0]      cr;
    logic [31:0]      cg;
    logic [31:0]      cb;
    logic [8:0]       resp;
    logic [8*8-1:0]   kind;
    logic [8*8-1:0]   op;
    logic [8*24-1:0]  name;
    logic [8*160-1:0] text;
    fd = $fopen("verification/frame_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open verification/frame_tests.txt");
      $display("Test failures found");
      $finish;
    end else begin
      while ($fgets(text, fd) > 0) begin
        kind = '0;
        name = '0;
        n = $sscanf(text, "%s", kind);
        if (kind == "apb") begin
          n = $sscanf(text, "%s %s %s %h %h %h %h", kind, name, op, addr, wdata, rdata, err);
          if (n != 7) begin
            $display("Test data line %0s has %0d fields instead of 7", name, n);
            fail_count++;
          end else begin
            apb_transfer(name, op == "w", addr[13:0], wdata[7:0], resp);
            check_value(name, {err[0], rdata[7:0]}, resp);
          end
        end else if (kind == "pix") begin
          n = $sscanf(text, "%s %s %d %d %h %h %h", kind, name, x, y, cr, cg, cb);
          if (n != 7) begin
            $display("Test data line %0s has %0d fields instead of 7", name, n);
            fail_count++;
          end else begin
            add_probe(name, raster_index(1, x, y), {cr[4:0], cg[5:0], cb[4:0]});
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One random cell in each of cell rows 12..19 is probed at one random pixel
  task automatic run_random_cells();
    int              k;
    int              row;
    int              col;
    int              pair;
    logic [7:0]      bits;
    logic [7:0]      attr;
    logic [8:0]      resp;
    logic [8*24-1:0] name;
    for (k = 0; k < 8; k++) begin
      rng_state = xorshift(rng_state);
      bits = rng_state[7:0];
      attr = {2'b00, rng_state[13:8]};
      row  = (12 + k) * 8 + rng_state[16:14];
      col  = rng_state[21:17];
      pair = rng_state[24:22];
      $sformat(name, "random_bits_%0d", k);
      apb_transfer(name, 1'b1, row * 32 + col, bits, resp);
      check_value(name, 0, resp);
      $sformat(name, "random_attr_%0d", k);
      apb_transfer(name, 1'b1, 14'h1800 + (row / 8) * 32 + col, attr, resp);
      check_value(name, 0, resp);
      $sformat(name, "random_pixel_%0d", k);
      add_probe(name, raster_index(1, 64 + col * 16 + pair * 2 + rng_state[25],
                                   48 + row * 2 + rng_state[26]),
                expand_colour(bits[7 - pair] ? attr[2:0] : attr[5:3]));
    end
  endtask

  initial begin
    int best;
    int i;
    int j;
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    pass_count  = 0;
    fail_count  = 0;
    probe_count = 0;
    rng_state   = 32'h41d9;
    repeat (8) @(negedge clock);
    check_value("reset_outputs", 0, {r, g, b, hs, vs, pready, pslverr});
    reset = 1'b0;
    #1;
    check_value("first_cycle_outputs", 0, {r, g, b, hs, vs, pready, pslverr});
    run_test_file();
    run_random_cells();
    // Sync edges in the first frame
    wait_output(raster_index(0, 655, 2));
    check_value("hs_low_at_655", 0, hs);
    wait_output(raster_index(0, 656, 2));
    check_value("hs_high_at_656", 1, hs);
    wait_output(raster_index(0, 751, 2));
    check_value("hs_high_at_751", 1, hs);
    wait_output(raster_index(0, 752, 2));
    check_value("hs_low_at_752", 0, hs);
    wait_output(raster_index(0, 655, 3));
    check_value("hs_low_next_line", 0, hs);
    wait_output(raster_index(0, 656, 3));
    check_value("hs_period_801", 1, hs);
    wait_output(raster_index(0, 800, 489));
    check_value("vs_low_at_489", 0, vs);
    wait_output(raster_index(0, 0, 490));
    check_value("vs_high_at_490", 1, vs);
    wait_output(raster_index(0, 800, 492));
    check_value("vs_high_at_492", 1, vs);
    wait_output(raster_index(0, 0, 493));
    check_value("vs_low_at_493", 0, vs);
    for (i = 0; i < probe_count; i++) begin
      best = -1;
      for (j = 0; j < probe_count; j++) begin
        if (!probe_done[j] && (best < 0 || probe_pos[j] < probe_pos[best])) begin
          best = j;
        end
      end
      probe_done[best] = 1'b1;
      wait_output(probe_pos[best]);
      check_value(probe_name[best], probe_rgb[best], {r, g, b});
    end
    $display("%0d checks ok, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/frame_tests.txt
# apb <name> <w|r> <addr hex> <wdata hex> <expected prdata hex> <expected pslverr>
# pix <name> <x> <y> <expected r hex> <expected g hex> <expected b hex>, second frame
apb wr_cell_a_bits w 0000 81 00 0
apb wr_cell_a_attr w 1800 2a 00 0
apb wr_cell_b_bits w 01bf 3c 00 0
apb wr_cell_b_attr w 183f 07 00 0
apb wr_cell_c_bits w 0bf0 a5 00 0
apb wr_cell_c_attr w 1970 0c 00 0
apb rd_cell_a_bits r 0000 00 81 0
apb rd_cell_a_attr r 1800 00 2a 0
apb rd_cell_b_bits r 01bf 00 3c 0
apb rd_cell_c_attr r 1970 00 0c 0
apb wr_last_legal w 1aff 77 00 0
apb rd_last_legal r 1aff 00 77 0
apb wr_alias_base w 0005 5a 00 0
apb wr_alias_high w 2005 ff 00 1
apb rd_alias_base r 0005 00 5a 0
apb wr_limit w 1b00 11 00 1
apb rd_limit r 1b00 00 00 1
apb rd_top r 3fff 00 00 1
pix border_top_left 10 10 0f 1f 0f
pix above_window 64 47 0f 1f 0f
pix left_of_window 63 48 0f 1f 0f
pix cell_a_first 64 48 0f 00 00
pix cell_a_pair_second 65 49 0f 00 00
pix cell_a_paper 66 48 00 1f 0f
pix cell_a_bit1_paper 77 48 00 1f 0f
pix cell_a_last_pair 78 48 0f 00 00
pix cell_a_last 79 49 0f 00 00
pix cell_b_first 560 74 00 00 00
pix cell_b_ink 564 74 0f 1f 0f
pix cell_b_ink_lower 565 75 0f 1f 0f
pix cell_b_bit1 572 74 00 00 00
pix cell_b_last 575 75 00 00 00
pix right_of_window 576 74 0f 1f 0f
pix blank_right 640 100 00 00 00
pix border_right 600 200 0f 1f 0f
pix cell_c_first 320 238 00 1f 00
pix cell_c_paper 322 239 00 00 0f
pix cell_c_bit1 333 238 00 00 0f
pix cell_c_last 335 239 00 1f 00
pix blank_hsync 700 300 00 00 00
pix below_window 320 432 0f 1f 0f
pix last_active 639 479 0f 1f 0f
pix blank_bottom 100 480 00 00 00
pix frame_end 800 525 00 00 00

// File: verilog.f
logic/video_timing_pkg.sv
logic/frame_pkg.sv
logic/raster_if.sv
logic/video_timing.sv
logic/apb_frame_port.sv
logic/frame_ram.sv
logic/bitmap_fetch.sv
logic/pixel_colour.sv
logic/video_top.sv
verification/video_top_tb.sv
